// File: design/csr_avmm_frontend.sv
// Avalon-MM handshake for the CSR slave. One request per two cycles.
// The master must hold its request until waitrequest goes low.
// Disabled bytes are zeroed on writes and on read data, never merged.
// readdata is only meaningful while readdatavalid is high.
`timescale 1ns/100ps

module csr_avmm_frontend (
   input  logic                        clk,
   input  logic                        reset_n,
   input  logic                        read,
   input  logic                        write,
   input  logic [csr_pkg::BE_W-1:0]    byteenable,
   input  logic [csr_pkg::DATA_W-1:0]  writedata,
   input  logic [csr_pkg::DATA_W-1:0]  rd_data_ctrl,
   input  logic [csr_pkg::DATA_W-1:0]  rd_data_queue,
   input  logic [csr_pkg::DATA_W-1:0]  rd_data_debug,
   output logic                        waitrequest,
   output logic                        readdatavalid,
   output logic [csr_pkg::DATA_W-1:0]  readdata,
   output logic                        wr_en,
   output logic [csr_pkg::DATA_W-1:0]  wr_data
);

   import csr_pkg::*;

   bus_state_t        state;
   bus_state_t        next_state;
   logic [DATA_W-1:0] be_mask;
   logic              read_accept;

   // one byteenable bit covers eight data bits
   always_comb begin
      for (int b = 0; b < BE_W; b++) begin
         be_mask[b*8 +: 8] = {8{byteenable[b]}};
      end
   end

   always_comb begin
      next_state = BUS_IDLE;
      case (state)
         BUS_IDLE: begin
            if (write) begin     // write wins over read
               next_state = BUS_WRITE;
            end else if (read) begin
               next_state = BUS_READ;
            end
         end
         BUS_WRITE: next_state = BUS_IDLE;
         BUS_READ:  next_state = BUS_IDLE;
         default:   next_state = BUS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= BUS_IDLE;
      end else begin
         state <= next_state;
      end
   end

   assign read_accept = (state == BUS_IDLE) && !write && read;

   // group outputs are zero unless the address is theirs, so OR is the mux
   always_ff @(posedge clk) begin
      if (read_accept) begin
         readdata <= (rd_data_ctrl | rd_data_queue | rd_data_debug) & be_mask;
      end
   end

   assign waitrequest   = (state == BUS_IDLE);
   assign readdatavalid = (state == BUS_READ);
   assign wr_en         = (state == BUS_WRITE);  // groups update at end of this cycle
   assign wr_data       = writedata & be_mask;

endmodule

// File: design/csr_avmm_slave.sv
// CSR slave for the storage accelerator, 64-bit Avalon-MM.
// Writes take effect two cycles after write is first sampled; read data
// is valid one cycle after read is first sampled, for exactly one cycle.
// Register outputs come straight from the registers, with no extra stage.
// Unmapped addresses read zero and ignore writes.
`timescale 1ns/100ps

module csr_avmm_slave (
   input  logic                             clk,
   input  logic                             reset_n,

   // Avalon-MM slave
   input  logic                             read,
   input  logic                             write,
   input  logic [csr_pkg::ADDR_W-1:0]       address,
   input  logic [csr_pkg::BE_W-1:0]         byteenable,
   input  logic [csr_pkg::DATA_W-1:0]       writedata,
   output logic                             waitrequest,
   output logic [csr_pkg::DATA_W-1:0]       readdata,
   output logic                             readdatavalid,

   input  logic [csr_pkg::DATA_W-1:0]       debug_pf [csr_pkg::NUM_DEBUG],

   // global control
   output logic                             start_proc,
   output logic                             end_proc,
   output logic                             update,
   output logic [csr_pkg::DATA_W-1:0]       requester_id,
   output logic [csr_pkg::DATA_W-1:0]       block_index_offset,
   output logic [csr_pkg::DATA_W-1:0]       bar_addr,
   output logic [csr_pkg::DATA_W-1:0]       afu_init,

   // nvme queue side
   output logic [csr_pkg::DATA_W-1:0]       sq_addr       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       cq_addr       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       sq_tail       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       cq_head       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       host_buf_addr [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::NUM_QUEUES-1:0]   host_buf_addr_valid
);

   import csr_pkg::*;

   logic                   wr_en;
   logic [DATA_W-1:0]      wr_data;
   logic [DATA_W-1:0]      rd_data_ctrl;
   logic [DATA_W-1:0]      rd_data_queue;
   logic [DATA_W-1:0]      rd_data_debug;
   logic [QUEUE_IDX_W-1:0] queue_sel;

   csr_avmm_frontend i_csr_avmm_frontend (
      .clk           (clk),
      .reset_n       (reset_n),
      .read          (read),
      .write         (write),
      .byteenable    (byteenable),
      .writedata     (writedata),
      .rd_data_ctrl  (rd_data_ctrl),
      .rd_data_queue (rd_data_queue),
      .rd_data_debug (rd_data_debug),
      .waitrequest   (waitrequest),
      .readdatavalid (readdatavalid),
      .readdata      (readdata),
      .wr_en         (wr_en),
      .wr_data       (wr_data)
   );

   csr_ctrl_regs i_csr_ctrl_regs (
      .clk                (clk),
      .reset_n            (reset_n),
      .wr_en              (wr_en),
      .address            (address),
      .wr_data            (wr_data),
      .rd_data            (rd_data_ctrl),
      .start_proc         (start_proc),
      .end_proc           (end_proc),
      .update             (update),
      .requester_id       (requester_id),
      .block_index_offset (block_index_offset),
      .bar_addr           (bar_addr),
      .afu_init           (afu_init),
      .queue_sel          (queue_sel)
   );

   csr_queue_regs i_csr_queue_regs (
      .clk                 (clk),
      .reset_n             (reset_n),
      .wr_en               (wr_en),
      .address             (address),
      .wr_data             (wr_data),
      .queue_sel           (queue_sel),
      .rd_data             (rd_data_queue),
      .sq_addr             (sq_addr),
      .cq_addr             (cq_addr),
      .sq_tail             (sq_tail),
      .cq_head             (cq_head),
      .host_buf_addr       (host_buf_addr),
      .host_buf_addr_valid (host_buf_addr_valid)
   );

   csr_debug_capture i_csr_debug_capture (
      .clk      (clk),
      .address  (address),
      .debug_pf (debug_pf),
      .rd_data  (rd_data_debug)
   );

endmodule

// File: design/csr_ctrl_regs.sv
// Global control registers of the accelerator.
// A command write of 1, 2 or 3 fires start, end or update for one cycle;
// any other value is stored and reads back without a pulse.
// Only the low QUEUE_IDX_W bits of the queue index reach the queue bank.
`timescale 1ns/100ps

module csr_ctrl_regs (
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic                             wr_en,
   input  logic [csr_pkg::ADDR_W-1:0]       address,
   input  logic [csr_pkg::DATA_W-1:0]       wr_data,
   output logic [csr_pkg::DATA_W-1:0]       rd_data,
   output logic                             start_proc,
   output logic                             end_proc,
   output logic                             update,
   output logic [csr_pkg::DATA_W-1:0]       requester_id,
   output logic [csr_pkg::DATA_W-1:0]       block_index_offset,
   output logic [csr_pkg::DATA_W-1:0]       bar_addr,
   output logic [csr_pkg::DATA_W-1:0]       afu_init,
   output logic [csr_pkg::QUEUE_IDX_W-1:0]  queue_sel
);

   import csr_pkg::*;

   logic [DATA_W-1:0] cmd_q;
   logic [DATA_W-1:0] queue_idx_q;
   csr_cmd_t          cmd_dec;

   // decode the command being written this cycle
   always_comb begin
      cmd_dec = CMD_NONE;
      if (wr_en && (address == ADDR_CMD)) begin
         case (wr_data)
            CMD_START:  cmd_dec = CMD_START;
            CMD_END:    cmd_dec = CMD_END;
            CMD_UPDATE: cmd_dec = CMD_UPDATE;
            default:    cmd_dec = CMD_NONE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         cmd_q              <= '0;
         requester_id       <= REQUESTER_ID_RST;
         block_index_offset <= '0;
         bar_addr           <= '0;
         afu_init           <= '0;
         queue_idx_q        <= '0;
         start_proc         <= 1'b0;
         end_proc           <= 1'b0;
         update             <= 1'b0;
      end else begin
         start_proc <= (cmd_dec == CMD_START);   // single cycle pulses
         end_proc   <= (cmd_dec == CMD_END);
         update     <= (cmd_dec == CMD_UPDATE);
         if (wr_en) begin
            case (address)
               ADDR_CMD:          cmd_q              <= wr_data;
               ADDR_REQUESTER_ID: requester_id       <= wr_data;
               ADDR_BLOCK_OFFSET: block_index_offset <= wr_data;
               ADDR_BAR:          bar_addr           <= wr_data;
               ADDR_AFU_INIT:     afu_init           <= wr_data;
               ADDR_QUEUE_IDX:    queue_idx_q        <= wr_data;
               default: ;   // not ours
            endcase
         end
      end
   end

   always_comb begin
      case (address)
         ADDR_CMD:          rd_data = cmd_q;
         ADDR_REQUESTER_ID: rd_data = requester_id;
         ADDR_BLOCK_OFFSET: rd_data = block_index_offset;
         ADDR_BAR:          rd_data = bar_addr;
         ADDR_AFU_INIT:     rd_data = afu_init;
         ADDR_QUEUE_IDX:    rd_data = queue_idx_q;
         default:           rd_data = '0;
      endcase
   end

   assign queue_sel = queue_idx_q[QUEUE_IDX_W-1:0];

endmodule

// File: design/csr_debug_capture.sv
// Snapshot of the debug performance counters, refreshed every cycle.
// A read returns the counter value from one cycle before the read edge.
// Only aligned addresses inside the debug window return data.
`timescale 1ns/100ps

module csr_debug_capture (
   input  logic                        clk,
   input  logic [csr_pkg::ADDR_W-1:0]  address,
   input  logic [csr_pkg::DATA_W-1:0]  debug_pf [csr_pkg::NUM_DEBUG],
   output logic [csr_pkg::DATA_W-1:0]  rd_data
);

   import csr_pkg::*;

   logic [DATA_W-1:0]      snap [NUM_DEBUG];
   logic [ADDR_W-1:0]      offset;
   logic [DEBUG_IDX_W-1:0] idx;
   logic                   in_window;

   always_ff @(posedge clk) begin
      for (int i = 0; i < NUM_DEBUG; i++) begin
         snap[i] <= debug_pf[i];
      end
   end

   assign offset    = address - ADDR_DEBUG_BASE;
   assign idx       = offset[3 +: DEBUG_IDX_W];   // 8 bytes per counter
   assign in_window = (address >= ADDR_DEBUG_BASE) && (address < ADDR_DEBUG_END) &&
                      (offset[2:0] == 3'b000);

   assign rd_data = in_window ? snap[idx] : '0;

endmodule

// File: design/csr_pkg.sv
// Shared definitions for the 64-bit Avalon-MM CSR slave.
// Byte addresses are 8-byte aligned; other offsets are not decoded.
// Queue registers are indexed through the queue index register, and
// only its low QUEUE_IDX_W bits select an entry.
package csr_pkg;

   localparam int DATA_W      = 64;
   localparam int ADDR_W      = 22;
   localparam int BE_W        = DATA_W / 8;
   localparam int NUM_QUEUES  = 4;
   localparam int QUEUE_IDX_W = 2;   // log2 of NUM_QUEUES
   localparam int NUM_DEBUG   = 8;
   localparam int DEBUG_IDX_W = $clog2(NUM_DEBUG);

   localparam logic [DATA_W-1:0] REQUESTER_ID_RST = 'h2a;

   // global control
   localparam logic [ADDR_W-1:0] ADDR_CMD          = 'h000;
   localparam logic [ADDR_W-1:0] ADDR_REQUESTER_ID = 'h008;
   localparam logic [ADDR_W-1:0] ADDR_BLOCK_OFFSET = 'h010;
   localparam logic [ADDR_W-1:0] ADDR_BAR          = 'h018;
   localparam logic [ADDR_W-1:0] ADDR_AFU_INIT     = 'h020;
   localparam logic [ADDR_W-1:0] ADDR_QUEUE_IDX    = 'h028;

   // per-queue window, entry picked by the queue index
   localparam logic [ADDR_W-1:0] ADDR_SQ_ADDR      = 'h030;
   localparam logic [ADDR_W-1:0] ADDR_CQ_ADDR      = 'h038;
   localparam logic [ADDR_W-1:0] ADDR_SQ_TAIL      = 'h040;
   localparam logic [ADDR_W-1:0] ADDR_CQ_HEAD      = 'h048;
   localparam logic [ADDR_W-1:0] ADDR_HOST_BUF     = 'h050;

   // debug counters, counter i at base + 8*i
   localparam logic [ADDR_W-1:0] ADDR_DEBUG_BASE   = 'h100;
   localparam logic [ADDR_W-1:0] ADDR_DEBUG_END    =
      ADDR_DEBUG_BASE + ADDR_W'(8 * NUM_DEBUG);

   // values written to the command register
   typedef enum logic [DATA_W-1:0] {
      CMD_NONE   = 'd0,
      CMD_START  = 'd1,
      CMD_END    = 'd2,
      CMD_UPDATE = 'd3
   } csr_cmd_t;

   // front end handshake states
   typedef enum logic [1:0] {
      BUS_IDLE  = 2'd0,
      BUS_WRITE = 2'd1,
      BUS_READ  = 2'd2
   } bus_state_t;

endpackage

// File: design/csr_queue_regs.sv
// Per-queue NVMe submission and completion queue registers.
// Reads and writes go to the entry chosen by queue_sel, so the queue
// index must be set before touching the queue window.
// A host buffer write raises that queue's valid bit for one cycle.
`timescale 1ns/100ps

module csr_queue_regs (
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic                             wr_en,
   input  logic [csr_pkg::ADDR_W-1:0]       address,
   input  logic [csr_pkg::DATA_W-1:0]       wr_data,
   input  logic [csr_pkg::QUEUE_IDX_W-1:0]  queue_sel,
   output logic [csr_pkg::DATA_W-1:0]       rd_data,
   output logic [csr_pkg::DATA_W-1:0]       sq_addr       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       cq_addr       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       sq_tail       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       cq_head       [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::DATA_W-1:0]       host_buf_addr [csr_pkg::NUM_QUEUES],
   output logic [csr_pkg::NUM_QUEUES-1:0]   host_buf_addr_valid
);

   import csr_pkg::*;

   logic host_buf_wr;

   assign host_buf_wr = wr_en && (address == ADDR_HOST_BUF);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         for (int q = 0; q < NUM_QUEUES; q++) begin
            sq_addr[q]       <= '0;
            cq_addr[q]       <= '0;
            sq_tail[q]       <= '0;
            cq_head[q]       <= '0;
            host_buf_addr[q] <= '0;
         end
         host_buf_addr_valid <= '0;
      end else begin
         host_buf_addr_valid <= '0;
         if (host_buf_wr) begin
            host_buf_addr_valid[queue_sel] <= 1'b1;   // only the selected queue
         end
         if (wr_en) begin
            case (address)
               ADDR_SQ_ADDR:  sq_addr[queue_sel]       <= wr_data;
               ADDR_CQ_ADDR:  cq_addr[queue_sel]       <= wr_data;
               ADDR_SQ_TAIL:  sq_tail[queue_sel]       <= wr_data;  // doorbell value
               ADDR_CQ_HEAD:  cq_head[queue_sel]       <= wr_data;
               ADDR_HOST_BUF: host_buf_addr[queue_sel] <= wr_data;
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (address)
         ADDR_SQ_ADDR:  rd_data = sq_addr[queue_sel];
         ADDR_CQ_ADDR:  rd_data = cq_addr[queue_sel];
         ADDR_SQ_TAIL:  rd_data = sq_tail[queue_sel];
         ADDR_CQ_HEAD:  rd_data = cq_head[queue_sel];
         ADDR_HOST_BUF: rd_data = host_buf_addr[queue_sel];
         default:       rd_data = '0;
      endcase
   end

endmodule

// File: filelist.f
design/csr_pkg.sv
design/csr_avmm_frontend.sv
design/csr_ctrl_regs.sv
design/csr_queue_regs.sv
design/csr_debug_capture.sv
design/csr_avmm_slave.sv
tb/csr_checker.sv
tb/tb_csr_avmm_slave.sv

// File: run.sh
#!/bin/sh
# builds and runs the CSR slave testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module tb_csr_avmm_slave \
   -o sim_csr_avmm_slave \
   && ./obj_dir/sim_csr_avmm_slave | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: tb/csr_checker.sv
// Monitor for the CSR slave testbench.
// Counts pulse and readdatavalid cycles over one table entry and compares
// them on entry_done; read data is compared whenever readdatavalid is high.
// exp_pulse bits are start, end, update, then host buffer valid 0 to 3.
`timescale 1ns/100ps

module csr_checker (
   input  logic                            clk,
   input  logic                            reset_n,
   input  logic                            readdatavalid,
   input  logic [csr_pkg::DATA_W-1:0]      readdata,
   input  logic                            start_proc,
   input  logic                            end_proc,
   input  logic                            update,
   input  logic [csr_pkg::NUM_QUEUES-1:0]  host_buf_addr_valid,
   input  logic [csr_pkg::DATA_W-1:0]      requester_id,
   input  logic [csr_pkg::DATA_W-1:0]      block_index_offset,
   input  logic [csr_pkg::DATA_W-1:0]      bar_addr,
   input  logic [csr_pkg::DATA_W-1:0]      afu_init,
   input  logic [csr_pkg::DATA_W-1:0]      sq_addr       [csr_pkg::NUM_QUEUES],
   input  logic [csr_pkg::DATA_W-1:0]      cq_addr       [csr_pkg::NUM_QUEUES],
   input  logic [csr_pkg::DATA_W-1:0]      sq_tail       [csr_pkg::NUM_QUEUES],
   input  logic [csr_pkg::DATA_W-1:0]      cq_head       [csr_pkg::NUM_QUEUES],
   input  logic [csr_pkg::DATA_W-1:0]      host_buf_addr [csr_pkg::NUM_QUEUES],
   input  logic                            entry_done,
   input  logic                            is_read,
   input  logic [csr_pkg::DATA_W-1:0]      exp_data,
   input  logic [6:0]                      exp_pulse,
   input  logic [3:0]                      obs_id,
   input  logic [1:0]                      obs_q,
   input  logic [127:0]                    test_name,
   output int                              mismatch_errors,
   output int                              pulse_errors
);

   import csr_pkg::*;

   int                cnt [7];
   int                rdv_cnt;
   logic [6:0]        now;
   logic [DATA_W-1:0] obs_val;

   assign now = {host_buf_addr_valid, update, end_proc, start_proc};

   // register output picked by the table entry
   always_comb begin
      case (obs_id)
         4'd1:    obs_val = requester_id;
         4'd2:    obs_val = block_index_offset;
         4'd3:    obs_val = bar_addr;
         4'd4:    obs_val = afu_init;
         4'd5:    obs_val = sq_addr[obs_q];
         4'd6:    obs_val = cq_addr[obs_q];
         4'd7:    obs_val = sq_tail[obs_q];
         4'd8:    obs_val = cq_head[obs_q];
         4'd9:    obs_val = host_buf_addr[obs_q];
         default: obs_val = '0;
      endcase
   end

   initial begin
      mismatch_errors = 0;
      pulse_errors    = 0;
      rdv_cnt         = 0;
      for (int k = 0; k < 7; k++) cnt[k] = 0;
   end

   always @(posedge clk) begin
      if (reset_n) begin
         if (readdatavalid && (readdata !== exp_data)) begin
            $display("Mismatch %0s readdata expected %h actual %h",
                     test_name, exp_data, readdata);
            mismatch_errors++;
         end
         for (int k = 0; k < 7; k++) begin
            if (now[k]) cnt[k]++;
         end
         if (readdatavalid) rdv_cnt++;
         if (entry_done) begin
            for (int k = 0; k < 7; k++) begin
               if (cnt[k] != int'(exp_pulse[k])) begin
                  $display("Mismatch %0s pulse %0d expected %0d actual %0d",
                           test_name, k, exp_pulse[k], cnt[k]);
                  pulse_errors++;
               end
               cnt[k] = 0;
            end
            if (rdv_cnt != (is_read ? 1 : 0)) begin
               $display("%0s gave %0d readdatavalid cycles instead of %0d",
                        test_name, rdv_cnt, is_read ? 1 : 0);
               pulse_errors++;
            end
            rdv_cnt = 0;
            if ((obs_id != 4'd0) && (obs_val !== exp_data)) begin
               $display("Mismatch %0s output expected %h actual %h",
                        test_name, exp_data, obs_val);
               mismatch_errors++;
            end
         end
      end
   end

endmodule

// File: tb/tb_csr_avmm_slave.sv
// Testbench for the Avalon-MM CSR slave.
// A stimulus table is built at time zero and applied in order; each
// request is held until waitrequest is seen low. Inputs change on the
// falling edge. debug_pf is loaded once from the LFSR and then held.
`timescale 1ns/100ps

module tb_csr_avmm_slave;

   import csr_pkg::*;

   localparam int          MAX_ENTRIES = 128;
   localparam logic [31:0] LFSR_SEED   = 32'h2c712772;
   localparam int          TIMEOUT_PAD = 50;

   logic              clk;
   logic              reset_n;
   logic              read;
   logic              write;
   logic [ADDR_W-1:0] address;
   logic [BE_W-1:0]   byteenable;
   logic [DATA_W-1:0] writedata;
   logic              waitrequest;
   logic [DATA_W-1:0] readdata;
   logic              readdatavalid;
   logic [DATA_W-1:0] debug_pf [NUM_DEBUG];
   logic              start_proc;
   logic              end_proc;
   logic              update;
   logic [DATA_W-1:0] requester_id;
   logic [DATA_W-1:0] block_index_offset;
   logic [DATA_W-1:0] bar_addr;
   logic [DATA_W-1:0] afu_init;
   logic [DATA_W-1:0] sq_addr       [NUM_QUEUES];
   logic [DATA_W-1:0] cq_addr       [NUM_QUEUES];
   logic [DATA_W-1:0] sq_tail       [NUM_QUEUES];
   logic [DATA_W-1:0] cq_head       [NUM_QUEUES];
   logic [DATA_W-1:0] host_buf_addr [NUM_QUEUES];
   logic [NUM_QUEUES-1:0] host_buf_addr_valid;

   // stimulus table
   logic [127:0]      t_name  [MAX_ENTRIES];
   logic              t_rd    [MAX_ENTRIES];
   logic [ADDR_W-1:0] t_addr  [MAX_ENTRIES];
   logic [BE_W-1:0]   t_be    [MAX_ENTRIES];
   logic [DATA_W-1:0] t_data  [MAX_ENTRIES];
   logic [DATA_W-1:0] t_exp   [MAX_ENTRIES];
   logic [6:0]        t_pulse [MAX_ENTRIES];
   logic [3:0]        t_obs   [MAX_ENTRIES];
   logic [1:0]        t_obsq  [MAX_ENTRIES];
   int                n_entries;

   // what the checker compares against for the current entry
   logic [127:0]      cur_name;
   logic              cur_rd;
   logic [DATA_W-1:0] cur_exp;
   logic [6:0]        cur_pulse;
   logic [3:0]        cur_obs;
   logic [1:0]        cur_obsq;
   logic              entry_done;

   logic [31:0]       lfsr_q;
   logic [DATA_W-1:0] dbg_val [NUM_DEBUG];
   logic [DATA_W-1:0] q_val   [NUM_QUEUES][5];
   int                cycle_count;
   int                cycle_limit;
   int                wait_cycles;
   int                other_errors;
   int                mismatch_errors;
   int                pulse_errors;

   csr_avmm_slave i_csr_avmm_slave (
      .clk (clk), .reset_n (reset_n),
      .read (read), .write (write), .address (address),
      .byteenable (byteenable), .writedata (writedata),
      .waitrequest (waitrequest), .readdata (readdata),
      .readdatavalid (readdatavalid), .debug_pf (debug_pf),
      .start_proc (start_proc), .end_proc (end_proc), .update (update),
      .requester_id (requester_id), .block_index_offset (block_index_offset),
      .bar_addr (bar_addr), .afu_init (afu_init),
      .sq_addr (sq_addr), .cq_addr (cq_addr), .sq_tail (sq_tail),
      .cq_head (cq_head), .host_buf_addr (host_buf_addr),
      .host_buf_addr_valid (host_buf_addr_valid)
   );

   csr_checker i_csr_checker (
      .clk (clk), .reset_n (reset_n),
      .readdatavalid (readdatavalid), .readdata (readdata),
      .start_proc (start_proc), .end_proc (end_proc), .update (update),
      .host_buf_addr_valid (host_buf_addr_valid),
      .requester_id (requester_id), .block_index_offset (block_index_offset),
      .bar_addr (bar_addr), .afu_init (afu_init),
      .sq_addr (sq_addr), .cq_addr (cq_addr), .sq_tail (sq_tail),
      .cq_head (cq_head), .host_buf_addr (host_buf_addr),
      .entry_done (entry_done), .is_read (cur_rd), .exp_data (cur_exp),
      .exp_pulse (cur_pulse), .obs_id (cur_obs), .obs_q (cur_obsq),
      .test_name (cur_name),
      .mismatch_errors (mismatch_errors), .pulse_errors (pulse_errors)
   );

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one lfsr step per bit taken
   function automatic logic [DATA_W-1:0] rand64();
      logic [DATA_W-1:0] r;
      r = '0;
      for (int b = 0; b < DATA_W; b++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r      = {r[DATA_W-2:0], lfsr_q[0]};
      end
      return r;
   endfunction

   task automatic add_entry(input logic [127:0] nm, input logic rd,
                            input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] be,
                            input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] e,
                            input logic [6:0] p, input logic [3:0] obs,
                            input logic [1:0] oq);
      t_name[n_entries]  = nm;
      t_rd[n_entries]    = rd;
      t_addr[n_entries]  = a;
      t_be[n_entries]    = be;
      t_data[n_entries]  = d;
      t_exp[n_entries]   = e;
      t_pulse[n_entries] = p;
      t_obs[n_entries]   = obs;
      t_obsq[n_entries]  = oq;
      n_entries++;
   endtask

   task automatic build_table();
      logic [DATA_W-1:0] d;
      logic [ADDR_W-1:0] a;
      logic [6:0]        p;
      n_entries = 0;
      // reset values, queue index is 0
      add_entry("rst_cmd", 1'b1, ADDR_CMD, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      add_entry("rst_reqid", 1'b1, ADDR_REQUESTER_ID, 8'hff, '0, 64'h2a, 7'd0, 4'd0, 2'd0);
      for (int r = 0; r < 4; r++) begin
         a = ADDR_BLOCK_OFFSET + ADDR_W'(8 * r);
         add_entry("rst_ctrl", 1'b1, a, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      end
      for (int r = 0; r < 5; r++) begin
         a = ADDR_SQ_ADDR + ADDR_W'(8 * r);
         add_entry("rst_queue", 1'b1, a, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      end
      // byte enables
      d = rand64();
      add_entry("be_full_wr", 1'b0, ADDR_BAR, 8'hff, d, d, 7'd0, 4'd3, 2'd0);
      add_entry("be_full_rd", 1'b1, ADDR_BAR, 8'hff, '0, d, 7'd0, 4'd0, 2'd0);
      add_entry("be_part_rd", 1'b1, ADDR_BAR, 8'hf0, '0, d & 64'hffffffff_00000000,
                7'd0, 4'd0, 2'd0);
      d = rand64();
      add_entry("be_part_wr", 1'b0, ADDR_BLOCK_OFFSET, 8'h0f, d,
                d & 64'h00000000_ffffffff, 7'd0, 4'd2, 2'd0);
      add_entry("be_part_rdback", 1'b1, ADDR_BLOCK_OFFSET, 8'hff, '0,
                d & 64'h00000000_ffffffff, 7'd0, 4'd0, 2'd0);
      add_entry("afu_wr", 1'b0, ADDR_AFU_INIT, 8'h81, 64'h1122334455667788,
                64'h1100000000000088, 7'd0, 4'd4, 2'd0);
      // unmapped addresses
      add_entry("unmap_wr", 1'b0, 22'h058, 8'hff, rand64(), '0, 7'd0, 4'd0, 2'd0);
      add_entry("unmap_rd", 1'b1, 22'h058, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      add_entry("unmap_rd_hi", 1'b1, 22'h200, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      add_entry("unmap_reqid", 1'b1, ADDR_REQUESTER_ID, 8'hff, '0, 64'h2a, 7'd0, 4'd1, 2'd0);
      // command pulses
      add_entry("cmd_start", 1'b0, ADDR_CMD, 8'hff, 64'd1, 64'd1, 7'b0000001, 4'd0, 2'd0);
      add_entry("cmd_start_rd", 1'b1, ADDR_CMD, 8'hff, '0, 64'd1, 7'd0, 4'd0, 2'd0);
      add_entry("cmd_end", 1'b0, ADDR_CMD, 8'hff, 64'd2, 64'd2, 7'b0000010, 4'd0, 2'd0);
      add_entry("cmd_update", 1'b0, ADDR_CMD, 8'hff, 64'd3, 64'd3, 7'b0000100, 4'd0, 2'd0);
      add_entry("cmd_other", 1'b0, ADDR_CMD, 8'hff, 64'd5, 64'd5, 7'd0, 4'd0, 2'd0);
      add_entry("cmd_other_rd", 1'b1, ADDR_CMD, 8'hff, '0, 64'd5, 7'd0, 4'd0, 2'd0);
      // queue bank, each entry written and read back through its index
      for (int q = 0; q < NUM_QUEUES; q++) begin
         add_entry("queue_idx_wr", 1'b0, ADDR_QUEUE_IDX, 8'hff, 64'(q), 64'(q),
                   7'd0, 4'd0, 2'd0);
         for (int r = 0; r < 5; r++) begin
            q_val[q][r] = rand64();
            a = ADDR_SQ_ADDR + ADDR_W'(8 * r);
            p = (r == 4) ? 7'(1 << (3 + q)) : 7'd0;   // host buffer valid bit
            add_entry("queue_wr", 1'b0, a, 8'hff, q_val[q][r], q_val[q][r], p,
                      4'(5 + r), 2'(q));
         end
         for (int r = 0; r < 5; r++) begin
            a = ADDR_SQ_ADDR + ADDR_W'(8 * r);
            add_entry("queue_rd", 1'b1, a, 8'hff, '0, q_val[q][r], 7'd0,
                      4'(5 + r), 2'(q));
         end
      end
      // queue 0 must survive the writes to the others
      add_entry("queue_idx_back", 1'b0, ADDR_QUEUE_IDX, 8'hff, '0, '0, 7'd0, 4'd0, 2'd0);
      add_entry("queue0_sq_keep", 1'b1, ADDR_SQ_ADDR, 8'hff, '0, q_val[0][0], 7'd0,
                4'd5, 2'd0);
      add_entry("queue0_hb_keep", 1'b1, ADDR_HOST_BUF, 8'hff, '0, q_val[0][4], 7'd0,
                4'd9, 2'd0);
      for (int i = 0; i < NUM_DEBUG; i++) begin
         a = ADDR_DEBUG_BASE + ADDR_W'(8 * i);
         add_entry("debug_rd", 1'b1, a, 8'hff, '0, dbg_val[i], 7'd0, 4'd0, 2'd0);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout after %0d cycles, the bus stopped answering", cycle_count);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      cycle_count  = 0;
      cycle_limit  = 100000;
      wait_cycles  = 0;
      other_errors = 0;
      reset_n      = 1'b0;
      read         = 1'b0;
      write        = 1'b0;
      address      = '0;
      byteenable   = '0;
      writedata    = '0;
      entry_done   = 1'b0;
      cur_name     = "reset";
      cur_rd       = 1'b0;
      cur_exp      = '0;
      cur_pulse    = '0;
      cur_obs      = '0;
      cur_obsq     = '0;
      lfsr_q       = LFSR_SEED;
      for (int i = 0; i < NUM_DEBUG; i++) begin
         dbg_val[i]  = rand64();
         debug_pf[i] = dbg_val[i];
      end
      build_table();
      cycle_limit = n_entries * 4 + TIMEOUT_PAD;
      repeat (5) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);
      if (!waitrequest) begin
         $display("waitrequest is low after reset with no request pending");
         other_errors++;
      end
      for (int k = 0; k < n_entries; k++) begin
         cur_name   = t_name[k];
         cur_rd     = t_rd[k];
         cur_exp    = t_exp[k];
         cur_pulse  = t_pulse[k];
         cur_obs    = t_obs[k];
         cur_obsq   = t_obsq[k];
         read       = t_rd[k];
         write      = !t_rd[k];
         address    = t_addr[k];
         byteenable = t_be[k];
         writedata  = t_data[k];
         entry_done = 1'b0;
         wait_cycles = 0;
         do begin
            @(negedge clk);
            wait_cycles++;
         end while (waitrequest);
         // read data is due in the one cycle that waitrequest is low
         if ((wait_cycles != 1) || (readdatavalid !== t_rd[k])) begin
            $display("%0s dropped waitrequest after %0d cycles with readdatavalid %b",
                     t_name[k], wait_cycles, readdatavalid);
            other_errors++;
         end
         @(negedge clk);
         read       = 1'b0;
         write      = 1'b0;
         entry_done = 1'b1;   // checker closes the entry on the next edge
         @(negedge clk);
      end
      entry_done = 1'b0;
      repeat (3) @(negedge clk);
      $display("errors: %0d mismatch, %0d pulse or handshake, %0d other",
               mismatch_errors, pulse_errors, other_errors);
      if (mismatch_errors + pulse_errors + other_errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule
